//--- rtl/addr_offset_pkg.sv
// --------------------
// Shared widths, table selectors and write-command types for the
// per-thread address offset unit. Every RTL module imports it.
// --------------------

package addr_offset_pkg;

    // --------------------
    // Sizes
    // --------------------

    localparam int ADDR_WIDTH   = 12;
    localparam int MATCH_WIDTH  = 4;
    localparam int PC_WIDTH     = 10;
    localparam int MAX_THREADS  = 4;
    localparam int BLOCK_COUNT  = 8;

    localparam int THREAD_WIDTH = $clog2(MAX_THREADS);
    localparam int BLOCK_WIDTH  = $clog2(BLOCK_COUNT);

    // --------------------
    // Basic types
    // --------------------

    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [PC_WIDTH-1:0]     pc_t;
    typedef logic [MATCH_WIDTH-1:0]  match_t;
    typedef logic [THREAD_WIDTH-1:0] thread_id_t;
    typedef logic [BLOCK_WIDTH-1:0]  block_id_t;

    // Target table of one configuration write
    typedef enum logic [2:0] {
        TBL_DEFAULT    = 3'd0,
        TBL_BLOCK      = 3'd1,
        TBL_MATCH      = 3'd2,
        TBL_PROGRAMMED = 3'd3,
        TBL_INCREMENT  = 3'd4
    } cfg_table_e;

    // Index is a thread number for the per-thread tables, a block number otherwise
    typedef struct packed {
        cfg_table_e  tbl;
        logic [2:0]  index;
        addr_t       data;
    } cfg_write_t;

    typedef struct packed {
        logic        valid;
        cfg_write_t  cfg;
    } wr_cmd_t;

    // Stage-2 block state handed from the block tracker to the offset unit
    typedef struct packed {
        block_id_t   block;
        logic        block_end;
    } blk_info_t;

endpackage

//--- rtl/thread_sequencer.sv
// --------------------
// Barrel thread counter. Gives the thread of the access entering
// stage 1 and the thread now in stage 2, which owns the writebacks.
// --------------------

`timescale 1ns/1ps

module thread_sequencer #(
    parameter int THREAD_COUNT = 4
) (
    input  logic                        clock,
    input  logic                        rst_n,
    output addr_offset_pkg::thread_id_t thread_s1,
    output addr_offset_pkg::thread_id_t thread_s2
);

    import addr_offset_pkg::*;

    // New thread every clock, whether or not the slot carries an access
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            thread_s1 <= '0;
        end else if (thread_s1 == thread_id_t'(THREAD_COUNT - 1)) begin
            thread_s1 <= '0;
        end else begin
            thread_s1 <= thread_s1 + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            thread_s2 <= '0;
        end else begin
            thread_s2 <= thread_s1;
        end
    end

endmodule

//--- rtl/cfg_port.sv
// --------------------
// Configuration port. Runs the four-phase req/ack handshake with the
// host and turns each transfer into a single-cycle table write command.
// --------------------

`timescale 1ns/1ps

module cfg_port (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        cfg_req,
    input  addr_offset_pkg::cfg_write_t cfg,
    output logic                        cfg_ack,
    output addr_offset_pkg::wr_cmd_t    wr_cmd
);

    import addr_offset_pkg::*;

    typedef enum logic {
        CFG_IDLE,
        CFG_ACKED
    } cfg_state_e;

    cfg_state_e state;
    logic       cmd_valid;
    cfg_write_t cmd_data;

    // --------------------
    // Handshake FSM
    // --------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state     <= CFG_IDLE;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            case (state)
                CFG_IDLE: begin
                    // Take the write on the first edge that sees the request
                    if (cfg_req) begin
                        cmd_valid <= 1'b1;
                        state     <= CFG_ACKED;
                    end
                end
                CFG_ACKED: begin
                    if (!cfg_req) begin
                        state <= CFG_IDLE;
                    end
                end
                default: state <= CFG_IDLE;
            endcase
        end
    end

    // The host holds cfg stable while the request is up
    always_ff @(posedge clock) begin
        if (state == CFG_IDLE && cfg_req) begin
            cmd_data <= cfg;
        end
    end

    assign cfg_ack = (state == CFG_ACKED);
    assign wr_cmd  = '{valid: cmd_valid, cfg: cmd_data};

endmodule

//--- rtl/block_tracker.sv
// --------------------
// Per-thread basic block counters and the shared block match memory.
// Flags the stage-2 access that ends its block and moves that thread on.
// --------------------

`timescale 1ns/1ps

module block_tracker (
    input  logic                        clock,
    input  logic                        rst_n,
    input  addr_offset_pkg::wr_cmd_t    wr_cmd,
    input  addr_offset_pkg::thread_id_t thread_s1,
    input  addr_offset_pkg::thread_id_t thread_s2,
    input  logic                        valid_s2,
    input  addr_offset_pkg::match_t     pc_lsb_s2,
    output addr_offset_pkg::blk_info_t  blk_info
);

    import addr_offset_pkg::*;

    // --------------------
    // Storage
    // --------------------

    block_id_t block_cnt [MAX_THREADS];
    match_t    match_mem [BLOCK_COUNT];

    block_id_t blk_s2;
    match_t    match_s2;
    logic      block_end;
    block_id_t next_blk;
    logic      cfg_wr_block;
    logic      cfg_wr_match;

    assign cfg_wr_block = wr_cmd.valid && (wr_cmd.cfg.tbl == TBL_BLOCK);
    assign cfg_wr_match = wr_cmd.valid && (wr_cmd.cfg.tbl == TBL_MATCH);

    // Stage 1 reads the block this thread sits in
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            blk_s2 <= '0;
        end else begin
            blk_s2 <= block_cnt[thread_s1];
        end
    end

    // --------------------
    // Stage 2 block end
    // --------------------

    assign match_s2  = match_mem[blk_s2];
    assign block_end = valid_s2 && (pc_lsb_s2 == match_s2);
    assign blk_info  = '{block: blk_s2, block_end: block_end};

    // Blocks run in order, so the next one is always one up
    always_comb begin
        if (blk_s2 == block_id_t'(BLOCK_COUNT - 1)) begin
            next_blk = '0;
        end else begin
            next_blk = blk_s2 + 1'b1;
        end
    end

    // A host write to the counters drops any advance in the same cycle
    always_ff @(posedge clock) begin
        if (cfg_wr_block) begin
            block_cnt[thread_id_t'(wr_cmd.cfg.index)] <= block_id_t'(wr_cmd.cfg.data);
        end else if (block_end) begin
            block_cnt[thread_s2] <= next_blk;
        end
    end

    always_ff @(posedge clock) begin
        if (cfg_wr_match) begin
            match_mem[block_id_t'(wr_cmd.cfg.index)] <= match_t'(wr_cmd.cfg.data);
        end
    end

endmodule

//--- rtl/offset_unit.sv
// --------------------
// Offset tables and the final address adder. Picks the default or the
// programmed offset, post-increments the programmed one at block end
// and registers addr_in plus offset as the output address.
// --------------------

`timescale 1ns/1ps

module offset_unit (
    input  logic                        clock,
    input  logic                        rst_n,
    input  addr_offset_pkg::wr_cmd_t    wr_cmd,
    input  addr_offset_pkg::thread_id_t thread_s1,
    input  addr_offset_pkg::blk_info_t  blk_info,
    input  logic                        valid_s2,
    input  addr_offset_pkg::addr_t      addr_s2,
    output addr_offset_pkg::addr_t      addr_out,
    output logic                        out_valid
);

    import addr_offset_pkg::*;

    // --------------------
    // Tables
    // --------------------

    addr_t default_tbl [MAX_THREADS];
    addr_t prog_tbl    [BLOCK_COUNT];
    addr_t incr_tbl    [BLOCK_COUNT];

    addr_t dflt_s2;
    addr_t prog_offset;
    addr_t incr;
    addr_t prog_next;
    addr_t offset;
    logic  cfg_wr_default;
    logic  cfg_wr_prog;
    logic  cfg_wr_incr;

    assign cfg_wr_default = wr_cmd.valid && (wr_cmd.cfg.tbl == TBL_DEFAULT);
    assign cfg_wr_prog    = wr_cmd.valid && (wr_cmd.cfg.tbl == TBL_PROGRAMMED);
    assign cfg_wr_incr    = wr_cmd.valid && (wr_cmd.cfg.tbl == TBL_INCREMENT);

    // Default offset is fetched a stage early, by thread
    always_ff @(posedge clock) begin
        dflt_s2 <= default_tbl[thread_s1];
    end

    always_ff @(posedge clock) begin
        if (cfg_wr_default) begin
            default_tbl[thread_id_t'(wr_cmd.cfg.index)] <= wr_cmd.cfg.data;
        end
    end

    // --------------------
    // Stage 2 selection
    // --------------------

    // Programmed offset and increment follow the block number of this cycle,
    // so a writeback is visible to the very next access
    assign prog_offset = prog_tbl[blk_info.block];
    assign incr        = incr_tbl[blk_info.block];
    assign prog_next   = prog_offset + incr;
    assign offset      = blk_info.block_end ? prog_offset : dflt_s2;

    // Post-increment at block end unless the host writes this table
    always_ff @(posedge clock) begin
        if (cfg_wr_prog) begin
            prog_tbl[block_id_t'(wr_cmd.cfg.index)] <= wr_cmd.cfg.data;
        end else if (blk_info.block_end) begin
            prog_tbl[blk_info.block] <= prog_next;
        end
    end

    always_ff @(posedge clock) begin
        if (cfg_wr_incr) begin
            incr_tbl[block_id_t'(wr_cmd.cfg.index)] <= wr_cmd.cfg.data;
        end
    end

    // --------------------
    // Output address
    // --------------------

    // Sum wraps at the address width
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            addr_out  <= '0;
            out_valid <= 1'b0;
        end else begin
            addr_out  <= addr_s2 + offset;
            out_valid <= valid_s2;
        end
    end

endmodule

//--- rtl/thread_offset_top.sv
// --------------------
// Top of the per-thread address offset unit. Carries the access into
// stage 2 and ties the thread, config, block and offset blocks together.
// --------------------

`timescale 1ns/1ps

module thread_offset_top #(
    parameter int THREAD_COUNT = 4
) (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  addr_offset_pkg::pc_t        pc,
    input  addr_offset_pkg::addr_t      addr_in,
    input  logic                        cfg_req,
    input  addr_offset_pkg::cfg_write_t cfg,
    output logic                        cfg_ack,
    output addr_offset_pkg::addr_t      addr_out,
    output logic                        out_valid
);

    import addr_offset_pkg::*;

    thread_id_t thread_s1;
    thread_id_t thread_s2;
    wr_cmd_t    wr_cmd;
    blk_info_t  blk_info;

    logic       valid_s2;
    match_t     pc_lsb_s2;
    addr_t      addr_s2;

    // --------------------
    // Stage 1 registers
    // --------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            valid_s2 <= 1'b0;
        end else begin
            valid_s2 <= in_valid;
        end
    end

    // Only the low PC bits take part in the block end compare
    always_ff @(posedge clock) begin
        pc_lsb_s2 <= pc[MATCH_WIDTH-1:0];
        addr_s2   <= addr_in;
    end

    // --------------------
    // Submodules
    // --------------------

    thread_sequencer #(
        .THREAD_COUNT (THREAD_COUNT)
    ) u_thread_sequencer (
        .clock     (clock),
        .rst_n     (rst_n),
        .thread_s1 (thread_s1),
        .thread_s2 (thread_s2)
    );

    cfg_port u_cfg_port (
        .clock   (clock),
        .rst_n   (rst_n),
        .cfg_req (cfg_req),
        .cfg     (cfg),
        .cfg_ack (cfg_ack),
        .wr_cmd  (wr_cmd)
    );

    block_tracker u_block_tracker (
        .clock     (clock),
        .rst_n     (rst_n),
        .wr_cmd    (wr_cmd),
        .thread_s1 (thread_s1),
        .thread_s2 (thread_s2),
        .valid_s2  (valid_s2),
        .pc_lsb_s2 (pc_lsb_s2),
        .blk_info  (blk_info)
    );

    offset_unit u_offset_unit (
        .clock     (clock),
        .rst_n     (rst_n),
        .wr_cmd    (wr_cmd),
        .thread_s1 (thread_s1),
        .blk_info  (blk_info),
        .valid_s2  (valid_s2),
        .addr_s2   (addr_s2),
        .addr_out  (addr_out),
        .out_valid (out_valid)
    );

endmodule

//--- sim/offset_checker.sv
// --------------------
// Watches the DUT outputs and compares them with the expected results
// pushed by the testbench, two cycles after each row. Counts errors
// and prints the summary line when asked to report.
// --------------------

`timescale 1ns/1ps

module offset_checker (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   out_valid,
    input  addr_offset_pkg::addr_t addr_out,
    input  logic                   cfg_ack,
    input  logic                   exp_valid,
    input  addr_offset_pkg::addr_t exp_addr,
    input  logic [127:0]           exp_name,
    input  logic                   report,
    input  int                     hs_errors,
    output int                     errors
);

    import addr_offset_pkg::*;

    // Expected results ride two stages to line up with the DUT output
    logic         valid_a = 1'b0;
    logic         valid_b = 1'b0;
    addr_t        addr_a  = '0;
    addr_t        addr_b  = '0;
    logic [127:0] name_a  = '0;
    logic [127:0] name_b  = '0;

    logic         armed   = 1'b0;
    logic         rst_q   = 1'b0;
    logic         done    = 1'b0;
    int           checks  = 0;
    int           err_cnt = 0;

    assign errors = err_cnt;

    always @(posedge clock) begin
        // Outputs are unknown before the first edge, so that one is skipped
        if (armed && !done) begin
            if (!rst_q) begin
                if (out_valid !== 1'b0) begin
                    $display("FAILED reset: out_valid expected 0 actual %0b", out_valid);
                    err_cnt = err_cnt + 1;
                end
                if (cfg_ack !== 1'b0) begin
                    $display("FAILED reset: cfg_ack expected 0 actual %0b", cfg_ack);
                    err_cnt = err_cnt + 1;
                end
            end else begin
                checks = checks + 1;
                if (out_valid !== valid_b) begin
                    $display("FAILED %s: out_valid expected %0b actual %0b",
                             name_b, valid_b, out_valid);
                    err_cnt = err_cnt + 1;
                end else if (valid_b && addr_out !== addr_b) begin
                    $display("FAILED %s: addr_out expected 0x%03h actual 0x%03h",
                             name_b, addr_b, addr_out);
                    err_cnt = err_cnt + 1;
                end
            end
            if (report) begin
                $display("Summary: %0d output checks, %0d output errors, %0d handshake errors",
                         checks, err_cnt, hs_errors);
                done = 1'b1;
            end
        end
        armed   <= 1'b1;
        rst_q   <= rst_n;
        valid_a <= exp_valid;
        addr_a  <= exp_addr;
        name_a  <= exp_name;
        valid_b <= valid_a;
        addr_b  <= addr_a;
        name_b  <= name_a;
    end

endmodule

//--- sim/tb_thread_offset.sv
// --------------------
// Testbench for the thread offset unit. Programs every table through
// the four-phase port, then plays the traffic table one row per cycle
// and hands the expected results to the checker.
// --------------------

`timescale 1ns/1ps

module tb_thread_offset;

    import addr_offset_pkg::*;

    localparam int NUM_ROWS        = 20;
    localparam int NUM_CFG         = 2 * MAX_THREADS + 3 * BLOCK_COUNT;
    localparam int WATCHDOG_CYCLES = NUM_CFG * 24 + NUM_ROWS + 50;

    typedef struct packed {
        logic [127:0] name;
        logic         valid;
        pc_t          pc;
        addr_t        addr;
        addr_t        exp;
        logic         rnd;
    } row_t;

    logic         clock = 1'b0;
    logic         rst_n;
    logic         in_valid;
    pc_t          pc;
    addr_t        addr_in;
    logic         cfg_req;
    cfg_write_t   cfg;
    logic         cfg_ack;
    addr_t        addr_out;
    logic         out_valid;

    logic         exp_valid;
    addr_t        exp_addr;
    logic [127:0] exp_name;
    logic         report;
    int           hs_errors = 0;
    int           chk_errors;
    integer       seed = 32'h099c6a91;

    // Thread of the access driven at the previous edge, read right after an edge
    logic [1:0]   prev_thread = 2'd0;

    row_t         rows [NUM_ROWS];

    // Table contents that the hand-worked expected values rely on
    addr_t dflt_val  [MAX_THREADS] = '{12'h100, 12'h200, 12'hF80, 12'h040};
    addr_t start_blk [MAX_THREADS] = '{12'd0, 12'd0, 12'd2, 12'd5};
    addr_t match_val [BLOCK_COUNT] = '{12'h3, 12'h7, 12'hA, 12'h5, 12'hC, 12'h9, 12'h1, 12'hE};

    always #4 clock = ~clock;

    always @(posedge clock) begin
        if (!rst_n) begin
            prev_thread <= 2'd0;
        end else begin
            prev_thread <= prev_thread + 1'b1;
        end
    end

    thread_offset_top #(
        .THREAD_COUNT (4)
    ) DUT (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .pc        (pc),
        .addr_in   (addr_in),
        .cfg_req   (cfg_req),
        .cfg       (cfg),
        .cfg_ack   (cfg_ack),
        .addr_out  (addr_out),
        .out_valid (out_valid)
    );

    offset_checker u_checker (
        .clock     (clock),
        .rst_n     (rst_n),
        .out_valid (out_valid),
        .addr_out  (addr_out),
        .cfg_ack   (cfg_ack),
        .exp_valid (exp_valid),
        .exp_addr  (exp_addr),
        .exp_name  (exp_name),
        .report    (report),
        .hs_errors (hs_errors),
        .errors    (chk_errors)
    );

    // --------------------
    // Configuration handshake
    // --------------------

    // Called right after an edge, returns right after an edge
    task automatic write_table(input cfg_table_e tbl, input int idx, input addr_t data);
        int waited;
        waited = 0;
        if (cfg_ack) begin
            $display("ERROR: cfg_ack was already high before a request to table %0d", tbl);
            hs_errors = hs_errors + 1;
        end
        cfg     <= '{tbl: tbl, index: 3'(idx), data: data};
        cfg_req <= 1'b1;
        @(posedge clock);
        while (!cfg_ack && waited < 20) begin
            @(posedge clock);
            waited = waited + 1;
        end
        if (!cfg_ack) begin
            $display("ERROR: configuration handshake stalled, cfg_ack never rose (table %0d)",
                     tbl);
            hs_errors = hs_errors + 1;
        end
        cfg_req <= 1'b0;
        waited = 0;
        @(posedge clock);
        while (cfg_ack && waited < 20) begin
            @(posedge clock);
            waited = waited + 1;
        end
        if (cfg_ack) begin
            $display("ERROR: cfg_ack stayed high after the request was dropped");
            hs_errors = hs_errors + 1;
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        row_t cur;
        in_valid  = 1'b0;
        pc        = '0;
        addr_in   = '0;
        cfg_req   = 1'b0;
        cfg       = '0;
        rst_n     = 1'b0;
        exp_valid = 1'b0;
        exp_addr  = '0;
        exp_name  = '0;
        report    = 1'b0;

        // Row i runs on thread i mod 4. Fields are name, valid, pc, addr_in, expected, random
        rows[0]  = '{"dflt_t0",         1'b1, 10'h00F, 12'h010, 12'h110, 1'b0};
        rows[1]  = '{"dflt_t1",         1'b1, 10'h02F, 12'h020, 12'h220, 1'b0};
        rows[2]  = '{"wrap_t2",         1'b1, 10'h0F0, 12'h0A0, 12'h020, 1'b0};
        rows[3]  = '{"dflt_t3",         1'b1, 10'h1F8, 12'h123, 12'h163, 1'b0};
        rows[4]  = '{"end_t0",          1'b1, 10'h013, 12'h200, 12'h500, 1'b0};
        rows[5]  = '{"share_t1",        1'b1, 10'h043, 12'h100, 12'h408, 1'b0};
        rows[6]  = '{"end_t2",          1'b1, 10'h03A, 12'h050, 12'h590, 1'b0};
        rows[7]  = '{"miss_t3",         1'b1, 10'h005, 12'h300, 12'h340, 1'b0};
        rows[8]  = '{"next_t0",         1'b1, 10'h007, 12'h001, 12'h421, 1'b0};
        rows[9]  = '{"old_match_t1",    1'b1, 10'h013, 12'h111, 12'h311, 1'b0};
        rows[10] = '{"rand_bubble_t2",  1'b0, 10'h005, 12'h000, 12'h000, 1'b1};
        rows[11] = '{"rand_bubble_t3",  1'b0, 10'h009, 12'h000, 12'h000, 1'b1};
        rows[12] = '{"post_inc_t0",     1'b1, 10'h00A, 12'h000, 12'h558, 1'b0};
        rows[13] = '{"rand_t1",         1'b1, 10'h3FF, 12'h000, 12'h000, 1'b1};
        rows[14] = '{"bubble_check_t2", 1'b1, 10'h015, 12'h020, 12'h680, 1'b0};
        rows[15] = '{"bubble_check_t3", 1'b1, 10'h009, 12'h7FF, 12'h09F, 1'b0};
        rows[16] = '{"shared_t0",       1'b1, 10'h025, 12'h004, 12'h684, 1'b0};
        rows[17] = '{"rand_t1b",        1'b1, 10'h3FF, 12'h000, 12'h000, 1'b1};
        rows[18] = '{"rand_bubble_t2b", 1'b0, 10'h00C, 12'h000, 12'h000, 1'b1};
        rows[19] = '{"end_t3",          1'b1, 10'h001, 12'h010, 12'h9D0, 1'b0};

        repeat (4) @(posedge clock);
        rst_n <= 1'b1;

        for (int t = 0; t < MAX_THREADS; t++) begin
            write_table(TBL_DEFAULT, t, dflt_val[t]);
            write_table(TBL_BLOCK, t, start_blk[t]);
        end
        for (int b = 0; b < BLOCK_COUNT; b++) begin
            write_table(TBL_MATCH, b, match_val[b]);
            write_table(TBL_PROGRAMMED, b, addr_t'(12'h300 + b * 12'h120));
            write_table(TBL_INCREMENT, b, addr_t'(8 * (b + 1)));
        end

        // Start on the slot that belongs to thread 0
        while (prev_thread != 2'd3) @(posedge clock);

        for (int i = 0; i < NUM_ROWS; i++) begin
            cur = rows[i];
            // Random rows miss their block, so they take the default offset
            if (cur.rnd) begin
                cur.addr = addr_t'($random(seed));
                cur.exp  = cur.addr + dflt_val[i % 4];
            end
            in_valid  <= cur.valid;
            pc        <= cur.pc;
            addr_in   <= cur.addr;
            exp_valid <= cur.valid;
            exp_addr  <= cur.exp;
            exp_name  <= cur.name;
            @(posedge clock);
        end
        in_valid  <= 1'b0;
        exp_valid <= 1'b0;
        repeat (4) @(posedge clock);
        report <= 1'b1;
        repeat (2) @(posedge clock);

        if (chk_errors == 0 && hs_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // --------------------
    // Watchdog
    // --------------------

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("ERROR: watchdog expired after %0d cycles, the run did not finish",
                 WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

//--- sources.f
rtl/addr_offset_pkg.sv
rtl/thread_sequencer.sv
rtl/cfg_port.sv
rtl/block_tracker.sv
rtl/offset_unit.sv
rtl/thread_offset_top.sv
sim/offset_checker.sv
sim/tb_thread_offset.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_thread_offset \
    -o tb_thread_offset > build.log 2>&1 \
    && ./obj_dir/tb_thread_offset > sim.log 2>&1 \
    || { echo "Build or simulation did not run, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log \
    && { echo "Simulation reported a failure"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
